//--- Makefile
SRCS = verilog/lsq_pkg.sv verilog/lsq_entry_queue.sv verilog/lsq_issue_ctrl.sv \
       verilog/lsq_mem_port.sv verilog/load_store_queue.sv bench/lsq_asserts.sv bench/lsq_tb.sv

.PHONY: run clean

obj_dir/Vlsq_tb: build.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f build.f --top-module lsq_tb -o Vlsq_tb

run: obj_dir/Vlsq_tb
	@out="$$(./obj_dir/Vlsq_tb)"; echo "$$out"; echo "$$out" | grep -qx "TEST RESULT: PASS"

clean:
	rm -rf obj_dir

//--- bench/lsq_asserts.sv
`timescale 1ns/1ps

module lsq_asserts
    import lsq_pkg::*;
(
    input logic       clk,
    input logic       rst,
    input lsq_state_t state,
    input logic       pop_load,
    input logic       pop_store,
    input logic [3:0] dmem_rmask,
    input logic [3:0] dmem_wmask,
    input logic       cdb_out_valid
);

    a_masks_exclusive: assert property (@(posedge clk) disable iff (rst)
        !((dmem_rmask != 4'b0) && (dmem_wmask != 4'b0)))
        else $error("read and write masks active together");

    // A load broadcasts in its single done cycle
    a_cdb_single: assert property (@(posedge clk) disable iff (rst)
        cdb_out_valid |=> !cdb_out_valid)
        else $error("result broadcast held for two cycles");

    a_pop_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0({pop_load, pop_store}))
        else $error("both queues popped together");

    a_pop_in_wait: assert property (@(posedge clk) disable iff (rst)
        (pop_load || pop_store) |-> (state inside {wait_load_pri, wait_store_pri}))
        else $error("pop outside a wait state");

endmodule

bind load_store_queue lsq_asserts u_asserts (
    .clk(clk), .rst(rst), .state(state), .pop_load(pop_load), .pop_store(pop_store),
    .dmem_rmask(dmem_rmask), .dmem_wmask(dmem_wmask), .cdb_out_valid(cdb_out_valid)
);

//--- bench/lsq_tb.sv
`timescale 1ns/1ps

module lsq_tb
    import lsq_pkg::*;
;

    logic clk, rst, flush, dispatch_valid, dispatch_rs1_ready, dispatch_rs2_ready;
    logic cdb_in_valid, commit_store, dmem_resp, full, cdb_out_valid;
    mem_op_t dispatch_op;
    logic [TAG_W-1:0] dispatch_rd, dispatch_rs1, dispatch_rs2, cdb_in_tag;
    logic [TAG_W-1:0] reg_rs1_sel, reg_rs2_sel, cdb_out_tag;
    logic [XLEN-1:0] dispatch_imm, reg_rs1_value, reg_rs2_value, dmem_rdata;
    logic [XLEN-1:0] dmem_addr, dmem_wdata, cdb_out_value;
    logic [3:0] dmem_rmask, dmem_wmask;

    // Register, readiness and memory models
    logic [XLEN-1:0] reg_val [64];
    logic            src_ready [64];
    logic [XLEN-1:0] ref_mem [64];
    logic [XLEN-1:0] dut_mem [64];

    // Operations dispatched but not yet issued in program order
    mem_op_t p_op[$];
    logic [TAG_W-1:0] p_rd[$], p_rs1[$], p_rs2[$];
    logic [XLEN-1:0] p_imm[$];
    logic [TAG_W-1:0] e_tag[$];
    logic [XLEN-1:0] e_val[$];

    integer seed = 4713;
    integer errors = 0, checks = 0, tests = 0, test_err = 0;
    integer req_count = 0, cdb_count = 0, mem_wait = 0, r0, c0;
    logic mem_busy = 1'b0;
    logic [XLEN-1:0] req_addr, req_wdata;
    logic [3:0] req_wmask;
    logic d_pend = 1'b0, bc_pend = 1'b0, flush_pend = 1'b0, rst_lvl = 1'b1, commit_lvl = 1'b1;
    mem_op_t d_op;
    logic [TAG_W-1:0] d_rd, d_rs1, d_rs2, bc_tag;
    logic [XLEN-1:0] d_imm;

    assign reg_rs1_value = reg_val[reg_rs1_sel];
    assign reg_rs2_value = reg_val[reg_rs2_sel];

    load_store_queue u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [3:0] size_mask(input mem_op_t op);
        case (op)
            op_lb, op_lbu, op_sb: return 4'b0001;
            op_lh, op_lhu, op_sh: return 4'b0011;
            default:              return 4'b1111;
        endcase
    endfunction

    function automatic logic [XLEN-1:0] extract(input mem_op_t op, input logic [XLEN-1:0] w,
                                                input logic [1:0] off);
        logic [XLEN-1:0] s;
        s = w >> (8 * off);
        case (op)
            op_lb:   return {{24{s[7]}}, s[7:0]};
            op_lbu:  return {24'h0, s[7:0]};
            op_lh:   return {{16{s[15]}}, s[15:0]};
            op_lhu:  return {16'h0, s[15:0]};
            default: return s;
        endcase
    endfunction

    function automatic logic [XLEN-1:0] merge(input logic [XLEN-1:0] old, data,
                                              input logic [3:0] mask);
        logic [XLEN-1:0] r;
        r = old;
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) r[8*b +: 8] = data[8*b +: 8];
        end
        return r;
    endfunction

    task automatic check(input string what, input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp);
        checks++;
        if (got !== exp) begin
            $display("ERROR %0t: %s got %h expected %h", $time, what, got, exp);
            errors++;
            test_err++;
        end
    endtask

    task automatic timed_out(input string what);
        $display("Timeout while %s", what);
        $display("TEST RESULT: FAIL");
        $finish;
    endtask

    // Check a new memory request against the sequential reference
    task automatic start_request();
        mem_op_t op;
        logic [TAG_W-1:0] rd, rs1, rs2;
        logic [XLEN-1:0] addr;
        logic st;
        req_count++;
        if (p_op.size() == 0) begin
            $display("Memory request seen with no pending operation at %0t", $time);
            errors++;
            test_err++;
        end else begin
            op = p_op.pop_front();
            rd = p_rd.pop_front();
            rs1 = p_rs1.pop_front();
            rs2 = p_rs2.pop_front();
            addr = reg_val[rs1] + p_imm.pop_front();
            st = op inside {op_sb, op_sh, op_sw};
            check("operands ready at issue", src_ready[rs1] && (!st || src_ready[rs2]), 1);
            check("dmem_addr", dmem_addr, {addr[XLEN-1:2], 2'b00});
            if (st) begin
                check("dmem_wmask", dmem_wmask, size_mask(op) << addr[1:0]);
                check("dmem_wdata", dmem_wdata, reg_val[rs2] << (8 * addr[1:0]));
                ref_mem[addr[7:2]] = merge(ref_mem[addr[7:2]], reg_val[rs2] << (8 * addr[1:0]),
                                           size_mask(op) << addr[1:0]);
            end else begin
                check("dmem_rmask", dmem_rmask, size_mask(op) << addr[1:0]);
                e_tag.push_back(rd);
                e_val.push_back(extract(op, ref_mem[addr[7:2]], addr[1:0]));
            end
        end
        mem_busy = 1'b1;
        mem_wait = 1 + ($unsigned($random(seed)) % 4);
        req_addr = dmem_addr;
        req_wmask = dmem_wmask;
        req_wdata = dmem_wdata;
    endtask

    // Drive on the falling edge and sample just after it
    task automatic step();
        @(negedge clk);
        rst = rst_lvl;
        commit_store = commit_lvl;
        if (mem_busy) begin
            if (dmem_resp) begin
                dmem_resp = 1'b0;
                mem_busy = 1'b0;
            end else if (mem_wait > 1) begin
                mem_wait--;
            end else begin
                dmem_resp = 1'b1;
                dmem_rdata = dut_mem[req_addr[7:2]];
                dut_mem[req_addr[7:2]] = merge(dut_mem[req_addr[7:2]], req_wdata, req_wmask);
            end
        end
        dispatch_valid = 1'b0;
        if (d_pend && !full) begin
            dispatch_valid = 1'b1;
            dispatch_op = d_op;
            dispatch_rd = d_rd;
            dispatch_rs1 = d_rs1;
            dispatch_rs2 = d_rs2;
            dispatch_imm = d_imm;
            dispatch_rs1_ready = src_ready[d_rs1];
            dispatch_rs2_ready = src_ready[d_rs2];
            p_op.push_back(d_op);
            p_rd.push_back(d_rd);
            p_rs1.push_back(d_rs1);
            p_rs2.push_back(d_rs2);
            p_imm.push_back(d_imm);
            d_pend = 1'b0;
        end
        cdb_in_valid = bc_pend;
        cdb_in_tag = bc_tag;
        if (bc_pend) src_ready[bc_tag] = 1'b1;
        bc_pend = 1'b0;
        flush = flush_pend;
        if (flush_pend) begin
            p_op.delete();
            p_rd.delete();
            p_rs1.delete();
            p_rs2.delete();
            p_imm.delete();
        end
        flush_pend = 1'b0;
        #1;
        if (!mem_busy && ((dmem_rmask != 4'b0) || (dmem_wmask != 4'b0))) start_request();
        if (cdb_out_valid) begin
            cdb_count++;
            if (e_tag.size() == 0) begin
                $display("Unexpected result broadcast at %0t", $time);
                errors++;
                test_err++;
            end else begin
                check("cdb_out_tag", cdb_out_tag, e_tag.pop_front());
                check("cdb_out_value", cdb_out_value, e_val.pop_front());
            end
        end
    endtask

    // Result bus broadcast in the next step
    task automatic queue_wakeup(input logic [TAG_W-1:0] tag);
        bc_pend = 1'b1;
        bc_tag = tag;
    endtask

    // A full queue drains only once its waiting operands arrive
    task automatic wake_first_pending();
        for (int t = 0; t < 32; t++) begin
            if (!src_ready[t] && !bc_pend) begin
                queue_wakeup(TAG_W'(t));
            end
        end
    endtask

    task automatic dispatch(input mem_op_t op, input logic [TAG_W-1:0] rd, rs1, rs2,
                            input logic [XLEN-1:0] imm);
        int n;
        d_op = op;
        d_rd = rd;
        d_rs1 = rs1;
        d_rs2 = rs2;
        d_imm = imm;
        d_pend = 1'b1;
        n = 0;
        while (d_pend && n < 200) begin
            if (full && !bc_pend) begin
                wake_first_pending();
            end
            step();
            n++;
        end
        if (d_pend) timed_out("waiting for full to drop");
    endtask

    task automatic random_op(input bit any_size, input bit late);
        mem_op_t op;
        logic [TAG_W-1:0] base, data, t;
        logic [1:0] sub;
        op = any_size ? mem_op_t'($unsigned($random(seed)) % 8)
                      : (($random(seed) & 1) ? op_sw : op_lw);
        base = $unsigned($random(seed)) % 16;
        data = 16 + $unsigned($random(seed)) % 16;
        sub = $random(seed);
        if (size_mask(op) == 4'b0011) sub[0] = 1'b0;
        if (size_mask(op) == 4'b1111) sub = 2'b00;
        if (late && !src_ready[base] && ($random(seed) & 1)) begin
            queue_wakeup(base);
        end
        dispatch(op, 32 + $unsigned($random(seed)) % 32, base, data,
                 4 * ($unsigned($random(seed)) % 32) + sub);
        t = $unsigned($random(seed)) % 32;
        if (late && !src_ready[t] && ($unsigned($random(seed)) % 3 == 0)) begin
            queue_wakeup(t);
            step();
        end
    endtask

    task automatic release_all();
        for (int t = 0; t < 32; t++) begin
            if (!src_ready[t]) begin
                queue_wakeup(TAG_W'(t));
                step();
            end
        end
    endtask

    task automatic drain();
        int n;
        n = 0;
        while ((p_op.size() != 0 || e_tag.size() != 0 || mem_busy) && n < 2000) begin
            step();
            n++;
        end
        if (n == 2000) timed_out("draining the queues");
        repeat (2) step();
    endtask

    task automatic compare_mem();
        for (int i = 0; i < 64; i++) check("memory word", dut_mem[i], ref_mem[i]);
    endtask

    task automatic end_test(input string name);
        $display("test %s: %0d errors", name, test_err);
        tests++;
        test_err = 0;
    endtask

    initial begin
        rst = 1'b1;
        flush = 1'b0;
        dispatch_valid = 1'b0;
        dispatch_rs1_ready = 1'b0;
        dispatch_rs2_ready = 1'b0;
        cdb_in_valid = 1'b0;
        commit_store = 1'b1;
        dmem_resp = 1'b0;
        dispatch_op = op_lw;
        dispatch_rd = '0;
        dispatch_rs1 = '0;
        dispatch_rs2 = '0;
        cdb_in_tag = '0;
        dispatch_imm = '0;
        dmem_rdata = '0;
        for (int t = 0; t < 64; t++) begin
            reg_val[t] = (t < 16) ? 8 * t : $random(seed);
            src_ready[t] = 1'b1;
        end
        for (int i = 0; i < 64; i++) begin
            ref_mem[i] = 32'h9e37_79b9 * (i + 1) ^ (i << 24);
            dut_mem[i] = ref_mem[i];
        end
        repeat (3) step();
        rst_lvl = 1'b0;
        step();
        check("full after reset", full, 0);
        check("masks after reset", {dmem_rmask, dmem_wmask}, 0);
        check("cdb_out_valid after reset", cdb_out_valid, 0);

        repeat (20) random_op(0, 0);
        drain();
        compare_mem();
        end_test("aligned");

        repeat (40) random_op(1, 0);
        drain();
        compare_mem();
        end_test("byte_half");

        for (int t = 0; t < 32; t++) begin
            if ($unsigned($random(seed)) % 3 == 0) src_ready[t] = 1'b0;
        end
        repeat (40) random_op(1, 1);
        release_all();
        drain();
        compare_mem();
        end_test("wakeup");

        commit_lvl = 1'b0;
        dispatch(op_sw, 0, 2, 20, 12);
        for (int i = 0; i < 3; i++) dispatch(op_lw, 40 + i, 2, 2, 4 * i + 8);
        r0 = req_count;
        c0 = cdb_count;
        repeat (40) step();
        check("requests while store held", req_count - r0, 0);
        check("broadcasts while store held", cdb_count - c0, 0);
        commit_lvl = 1'b1;
        drain();
        compare_mem();
        end_test("commit");

        src_ready[5] = 1'b0;
        for (int i = 0; i < 8; i++) dispatch(op_lw, 32 + i, 5, 5, 4 * i);
        step();
        check("full with eight waiting loads", full, 1);
        queue_wakeup(5);
        drain();
        check("full after drain", full, 0);
        end_test("full");

        src_ready[6] = 1'b0;
        dispatch(op_lw, 50, 6, 6, 4);
        dispatch(op_sw, 0, 6, 21, 8);
        dispatch(op_lbu, 51, 6, 6, 3);
        dispatch(op_sh, 0, 6, 22, 2);
        for (int i = 0; i < 6; i++) dispatch(op_lw, 52 + i, 6, 6, 4 * i);
        repeat (3) step();
        check("full before flush", full, 1);
        r0 = req_count;
        c0 = cdb_count;
        flush_pend = 1'b1;
        step();
        // Operands arrive after the flush and must find nothing to wake
        queue_wakeup(6);
        repeat (20) step();
        check("requests after flush", req_count - r0, 0);
        check("broadcasts after flush", cdb_count - c0, 0);
        check("full after flush", full, 0);
        repeat (10) random_op(1, 0);
        drain();
        compare_mem();
        end_test("flush");

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- build.f
verilog/lsq_pkg.sv
verilog/lsq_entry_queue.sv
verilog/lsq_issue_ctrl.sv
verilog/lsq_mem_port.sv
verilog/load_store_queue.sv
bench/lsq_asserts.sv
bench/lsq_tb.sv

//--- verilog/load_store_queue.sv
`timescale 1ns/1ps

module load_store_queue
    import lsq_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic             flush,
    input  logic             dispatch_valid,
    input  mem_op_t          dispatch_op,
    input  logic [TAG_W-1:0] dispatch_rd,
    input  logic [TAG_W-1:0] dispatch_rs1,
    input  logic [TAG_W-1:0] dispatch_rs2,
    input  logic             dispatch_rs1_ready,
    input  logic             dispatch_rs2_ready,
    input  logic [XLEN-1:0]  dispatch_imm,
    input  logic             cdb_in_valid,
    input  logic [TAG_W-1:0] cdb_in_tag,
    input  logic             commit_store,
    input  logic [XLEN-1:0]  reg_rs1_value,
    input  logic [XLEN-1:0]  reg_rs2_value,
    input  logic [XLEN-1:0]  dmem_rdata,
    input  logic             dmem_resp,
    output logic             full,
    output logic [TAG_W-1:0] reg_rs1_sel,
    output logic [TAG_W-1:0] reg_rs2_sel,
    output logic [XLEN-1:0]  dmem_addr,
    output logic [3:0]       dmem_rmask,
    output logic [3:0]       dmem_wmask,
    output logic [XLEN-1:0]  dmem_wdata,
    output logic             cdb_out_valid,
    output logic [TAG_W-1:0] cdb_out_tag,
    output logic [XLEN-1:0]  cdb_out_value
);

    logic is_store;
    logic push_load;
    logic push_store;
    logic load_full;
    logic store_full;
    logic load_ready;
    logic store_ready;
    logic pop_load;
    logic pop_store;
    logic block_cdb;

    logic [QPTR_W-1:0] load_head;
    logic [QPTR_W-1:0] load_tail;
    logic [QPTR_W-1:0] store_head;
    logic [QPTR_W-1:0] store_tail;

    mem_op_t          ld_head_op;
    logic [TAG_W-1:0] ld_head_rd;
    logic [TAG_W-1:0] ld_head_rs1;
    logic [XLEN-1:0]  ld_head_imm;
    mem_op_t          st_head_op;
    logic [TAG_W-1:0] st_head_rs1;
    logic [TAG_W-1:0] st_head_rs2;
    logic [XLEN-1:0]  st_head_imm;
    lsq_state_t       state;

    assign is_store   = dispatch_op inside {op_sb, op_sh, op_sw};
    assign push_load  = dispatch_valid && !is_store && !load_full;
    assign push_store = dispatch_valid && is_store && !store_full;
    assign full       = load_full || store_full;

    // Loads have no second source, so rs2 counts as ready
    lsq_entry_queue u_load_queue (
        .clk(clk), .rst(rst), .flush(flush), .push(push_load),
        .push_op(dispatch_op), .push_rd(dispatch_rd),
        .push_rs1(dispatch_rs1), .push_rs2(dispatch_rs2),
        .push_rs1_ready(dispatch_rs1_ready), .push_rs2_ready(1'b1),
        .push_imm(dispatch_imm), .other_head_ptr(store_head), .other_tail_ptr(store_tail),
        .cdb_in_valid(cdb_in_valid), .cdb_in_tag(cdb_in_tag), .pop(pop_load),
        .head_ptr(load_head), .tail_ptr(load_tail), .queue_full(load_full),
        .head_ready(load_ready), .head_op(ld_head_op), .head_rd(ld_head_rd),
        .head_rs1(ld_head_rs1), .head_rs2(), .head_imm(ld_head_imm)
    );

    lsq_entry_queue u_store_queue (
        .clk(clk), .rst(rst), .flush(flush), .push(push_store),
        .push_op(dispatch_op), .push_rd(dispatch_rd),
        .push_rs1(dispatch_rs1), .push_rs2(dispatch_rs2),
        .push_rs1_ready(dispatch_rs1_ready), .push_rs2_ready(dispatch_rs2_ready),
        .push_imm(dispatch_imm), .other_head_ptr(load_head), .other_tail_ptr(load_tail),
        .cdb_in_valid(cdb_in_valid), .cdb_in_tag(cdb_in_tag), .pop(pop_store),
        .head_ptr(store_head), .tail_ptr(store_tail), .queue_full(store_full),
        .head_ready(store_ready), .head_op(st_head_op), .head_rd(),
        .head_rs1(st_head_rs1), .head_rs2(st_head_rs2), .head_imm(st_head_imm)
    );

    lsq_issue_ctrl u_issue_ctrl (
        .clk(clk), .rst(rst), .flush(flush),
        .load_ready(load_ready), .store_ready(store_ready),
        .commit_store(commit_store), .dmem_resp(dmem_resp),
        .state(state), .pop_load(pop_load), .pop_store(pop_store), .block_cdb(block_cdb)
    );

    lsq_mem_port u_mem_port (
        .clk(clk), .rst(rst), .state(state), .block_cdb(block_cdb),
        .pop_load(pop_load), .pop_store(pop_store),
        .ld_head_op(ld_head_op), .ld_head_rd(ld_head_rd),
        .ld_head_rs1(ld_head_rs1), .ld_head_imm(ld_head_imm),
        .st_head_op(st_head_op), .st_head_rs1(st_head_rs1),
        .st_head_rs2(st_head_rs2), .st_head_imm(st_head_imm),
        .reg_rs1_value(reg_rs1_value), .reg_rs2_value(reg_rs2_value),
        .dmem_rdata(dmem_rdata), .dmem_resp(dmem_resp),
        .reg_rs1_sel(reg_rs1_sel), .reg_rs2_sel(reg_rs2_sel),
        .dmem_addr(dmem_addr), .dmem_rmask(dmem_rmask), .dmem_wmask(dmem_wmask),
        .dmem_wdata(dmem_wdata), .cdb_out_valid(cdb_out_valid),
        .cdb_out_tag(cdb_out_tag), .cdb_out_value(cdb_out_value)
    );

endmodule

//--- verilog/lsq_entry_queue.sv
`timescale 1ns/1ps

module lsq_entry_queue
    import lsq_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              flush,
    input  logic              push,
    input  mem_op_t           push_op,
    input  logic [TAG_W-1:0]  push_rd,
    input  logic [TAG_W-1:0]  push_rs1,
    input  logic [TAG_W-1:0]  push_rs2,
    input  logic              push_rs1_ready,
    input  logic              push_rs2_ready,
    input  logic [XLEN-1:0]   push_imm,
    input  logic [QPTR_W-1:0] other_head_ptr,
    input  logic [QPTR_W-1:0] other_tail_ptr,
    input  logic              cdb_in_valid,
    input  logic [TAG_W-1:0]  cdb_in_tag,
    input  logic              pop,
    output logic [QPTR_W-1:0] head_ptr,
    output logic [QPTR_W-1:0] tail_ptr,
    output logic              queue_full,
    output logic              head_ready,
    output mem_op_t           head_op,
    output logic [TAG_W-1:0]  head_rd,
    output logic [TAG_W-1:0]  head_rs1,
    output logic [TAG_W-1:0]  head_rs2,
    output logic [XLEN-1:0]   head_imm
);

    logic              valid     [QUEUE_DEPTH];
    mem_op_t           op        [QUEUE_DEPTH];
    logic [TAG_W-1:0]  rd        [QUEUE_DEPTH];
    logic [TAG_W-1:0]  rs1       [QUEUE_DEPTH];
    logic [TAG_W-1:0]  rs2       [QUEUE_DEPTH];
    logic [XLEN-1:0]   imm       [QUEUE_DEPTH];
    logic              rs1_rdy   [QUEUE_DEPTH];
    logic              rs2_rdy   [QUEUE_DEPTH];
    logic [QPTR_W-1:0] cross_ptr [QUEUE_DEPTH];
    logic              cross_met [QUEUE_DEPTH];
    logic [QPTR_W:0]   count;

    logic push_rs1_hit;
    logic push_rs2_hit;
    logic order_ok;

    // Result bus may deliver an operand in the same cycle it is dispatched
    assign push_rs1_hit = cdb_in_valid && (cdb_in_tag == push_rs1);
    assign push_rs2_hit = cdb_in_valid && (cdb_in_tag == push_rs2);

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            count    <= '0;
        end else begin
            if (push) begin
                head_ptr <= head_ptr + 1'b1;
            end
            if (pop) begin
                tail_ptr <= tail_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            for (int i = 0; i < QUEUE_DEPTH; i++) begin
                valid[i] <= 1'b0;
            end
        end else begin
            if (pop) begin
                valid[tail_ptr] <= 1'b0;
            end
            if (push) begin
                valid[head_ptr] <= 1'b1;
            end
        end
    end

    // Wakeup and cross-order tracking, the push slot overrides below
    always_ff @(posedge clk) begin
        for (int i = 0; i < QUEUE_DEPTH; i++) begin
            if (valid[i] && cdb_in_valid && (cdb_in_tag == rs1[i])) begin
                rs1_rdy[i] <= 1'b1;
            end
            if (valid[i] && cdb_in_valid && (cdb_in_tag == rs2[i])) begin
                rs2_rdy[i] <= 1'b1;
            end
            if (valid[i] && (cross_ptr[i] == other_tail_ptr)) begin
                cross_met[i] <= 1'b1;
            end
        end
        if (push) begin
            op[head_ptr]        <= push_op;
            rd[head_ptr]        <= push_rd;
            rs1[head_ptr]       <= push_rs1;
            rs2[head_ptr]       <= push_rs2;
            imm[head_ptr]       <= push_imm;
            rs1_rdy[head_ptr]   <= push_rs1_ready || push_rs1_hit;
            rs2_rdy[head_ptr]   <= push_rs2_ready || push_rs2_hit;
            // Older ops of the other queue end at its current head
            cross_ptr[head_ptr] <= other_head_ptr;
            cross_met[head_ptr] <= 1'b0;
        end
    end

    // Other queue has drained everything that was ahead of the oldest entry
    assign order_ok = cross_met[tail_ptr] || (cross_ptr[tail_ptr] == other_tail_ptr);

    assign head_ready = valid[tail_ptr] && rs1_rdy[tail_ptr] && rs2_rdy[tail_ptr] && order_ok;
    assign queue_full = (count == QUEUE_DEPTH);

    assign head_op  = op[tail_ptr];
    assign head_rd  = rd[tail_ptr];
    assign head_rs1 = rs1[tail_ptr];
    assign head_rs2 = rs2[tail_ptr];
    assign head_imm = imm[tail_ptr];

endmodule

//--- verilog/lsq_issue_ctrl.sv
`timescale 1ns/1ps

module lsq_issue_ctrl
    import lsq_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       flush,
    input  logic       load_ready,
    input  logic       store_ready,
    input  logic       commit_store,
    input  logic       dmem_resp,
    output lsq_state_t state,
    output logic       pop_load,
    output logic       pop_store,
    output logic       block_cdb
);

    lsq_state_t next_state;

    logic in_wait;
    logic in_request;
    logic store_ok;

    assign in_wait    = (state == wait_load_pri) || (state == wait_store_pri);
    assign in_request = (state == request_load) || (state == request_store);

    // Stores leave only once the ROB has committed them
    assign store_ok = store_ready && commit_store;

    always_comb begin
        pop_load  = 1'b0;
        pop_store = 1'b0;
        if (in_wait && !flush) begin
            if (load_ready && store_ok) begin
                // Tie goes to the queue favoured by the current wait state
                if (state == wait_load_pri) begin
                    pop_load = 1'b1;
                end else begin
                    pop_store = 1'b1;
                end
            end else if (load_ready) begin
                pop_load = 1'b1;
            end else if (store_ok) begin
                pop_store = 1'b1;
            end
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            wait_load_pri, wait_store_pri: begin
                if (pop_load) begin
                    next_state = request_load;
                end else if (pop_store) begin
                    next_state = request_store;
                end
            end
            request_load: begin
                if (dmem_resp) begin
                    next_state = done_load;
                end
            end
            request_store: begin
                if (dmem_resp) begin
                    next_state = done_store;
                end
            end
            // Hand priority to the other queue so neither starves
            done_load:  next_state = wait_store_pri;
            done_store: next_state = wait_load_pri;
            default:    next_state = wait_load_pri;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= wait_load_pri;
        end else begin
            state <= next_state;
        end
    end

    // Request already at memory finishes, but its result is stale after flush
    always_ff @(posedge clk) begin
        if (rst) begin
            block_cdb <= 1'b0;
        end else if (in_request && flush) begin
            block_cdb <= 1'b1;
        end else if ((state == done_load) || (state == done_store)) begin
            block_cdb <= 1'b0;
        end
    end

endmodule

//--- verilog/lsq_mem_port.sv
`timescale 1ns/1ps

module lsq_mem_port
    import lsq_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  lsq_state_t       state,
    input  logic             block_cdb,
    input  logic             pop_load,
    input  logic             pop_store,
    input  mem_op_t          ld_head_op,
    input  logic [TAG_W-1:0] ld_head_rd,
    input  logic [TAG_W-1:0] ld_head_rs1,
    input  logic [XLEN-1:0]  ld_head_imm,
    input  mem_op_t          st_head_op,
    input  logic [TAG_W-1:0] st_head_rs1,
    input  logic [TAG_W-1:0] st_head_rs2,
    input  logic [XLEN-1:0]  st_head_imm,
    input  logic [XLEN-1:0]  reg_rs1_value,
    input  logic [XLEN-1:0]  reg_rs2_value,
    input  logic [XLEN-1:0]  dmem_rdata,
    input  logic             dmem_resp,
    output logic [TAG_W-1:0] reg_rs1_sel,
    output logic [TAG_W-1:0] reg_rs2_sel,
    output logic [XLEN-1:0]  dmem_addr,
    output logic [3:0]       dmem_rmask,
    output logic [3:0]       dmem_wmask,
    output logic [XLEN-1:0]  dmem_wdata,
    output logic             cdb_out_valid,
    output logic [TAG_W-1:0] cdb_out_tag,
    output logic [XLEN-1:0]  cdb_out_value
);

    mem_op_t          op_q;
    logic [TAG_W-1:0] rd_q;
    logic [XLEN-1:0]  addr_q;
    logic [XLEN-1:0]  wdata_q;
    logic [XLEN-1:0]  load_value_q;

    logic [3:0]       size_mask;
    logic [3:0]       byte_mask;
    logic [XLEN-1:0]  rdata_shifted;
    logic [XLEN-1:0]  load_value;

    // Register file answers in the pop cycle
    assign reg_rs1_sel = pop_store ? st_head_rs1 : ld_head_rs1;
    assign reg_rs2_sel = st_head_rs2;

    always_ff @(posedge clk) begin
        if (rst) begin
            op_q   <= op_lw;
            addr_q <= '0;
        end else if (pop_load) begin
            op_q   <= ld_head_op;
            addr_q <= reg_rs1_value + ld_head_imm;
        end else if (pop_store) begin
            op_q   <= st_head_op;
            addr_q <= reg_rs1_value + st_head_imm;
        end
    end

    always_ff @(posedge clk) begin
        if (pop_load) begin
            rd_q <= ld_head_rd;
        end
        if (pop_store) begin
            wdata_q <= reg_rs2_value;
        end
        if ((state == request_load) && dmem_resp) begin
            load_value_q <= load_value;
        end
    end

    always_comb begin
        case (op_q)
            op_lb, op_lbu, op_sb: size_mask = 4'b0001;
            op_lh, op_lhu, op_sh: size_mask = 4'b0011;
            default:              size_mask = 4'b1111;
        endcase
    end

    assign byte_mask = size_mask << addr_q[1:0];

    always_comb begin
        dmem_addr  = '0;
        dmem_rmask = 4'b0000;
        dmem_wmask = 4'b0000;
        dmem_wdata = '0;
        if (state == request_load) begin
            dmem_addr  = {addr_q[XLEN-1:2], 2'b00};
            dmem_rmask = byte_mask;
        end else if (state == request_store) begin
            dmem_addr  = {addr_q[XLEN-1:2], 2'b00};
            dmem_wmask = byte_mask;
            dmem_wdata = wdata_q << {addr_q[1:0], 3'b000};
        end
    end

    // Bring the addressed bytes down to bit 0 before extension
    assign rdata_shifted = dmem_rdata >> {addr_q[1:0], 3'b000};

    always_comb begin
        case (op_q)
            op_lb:   load_value = {{(XLEN-8){rdata_shifted[7]}}, rdata_shifted[7:0]};
            op_lbu:  load_value = {{(XLEN-8){1'b0}}, rdata_shifted[7:0]};
            op_lh:   load_value = {{(XLEN-16){rdata_shifted[15]}}, rdata_shifted[15:0]};
            op_lhu:  load_value = {{(XLEN-16){1'b0}}, rdata_shifted[15:0]};
            default: load_value = rdata_shifted;
        endcase
    end

    assign cdb_out_valid = (state == done_load) && !block_cdb;
    assign cdb_out_tag   = rd_q;
    assign cdb_out_value = load_value_q;

endmodule

//--- verilog/lsq_pkg.sv
package lsq_pkg;

    // Data path and address width
    localparam int XLEN = 32;

    // Entries in each of the load and store queues
    localparam int QUEUE_DEPTH = 8;
    localparam int QPTR_W = $clog2(QUEUE_DEPTH);

    // Physical register tag width
    localparam int TAG_W = 6;

    // Memory opcodes, loads first
    typedef enum logic [2:0] {
        op_lb  = 3'd0,
        op_lh  = 3'd1,
        op_lw  = 3'd2,
        op_lbu = 3'd3,
        op_lhu = 3'd4,
        op_sb  = 3'd5,
        op_sh  = 3'd6,
        op_sw  = 3'd7
    } mem_op_t;

    // Issue controller states
    // The two wait states differ only in which queue wins a tie
    typedef enum logic [2:0] {
        wait_load_pri  = 3'd0,
        wait_store_pri = 3'd1,
        request_load   = 3'd2,
        request_store  = 3'd3,
        done_load      = 3'd4,
        done_store     = 3'd5
    } lsq_state_t;

endpackage
